// ==== Makefile ====
# Verilator build and run of the read DMA regression

VERILATOR ?= verilator
TOP       ?= tb_dma_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard logic/*.sv) $(wildcard bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/axi_rd_mem.sv ====
// ==============================
// AXI4 read slave model, data is
// the beat address, random stalls
// ==============================

`timescale 1ns/1ps

module axi_rd_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [63:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    // Accepted bursts, served strictly in AR order
    logic [31:0] q_addr[$];
    logic [7:0]  q_len[$];
    logic [3:0]  q_id[$];
    logic [31:0] lfsr;
    int          beat;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rlast   = 1'b0;
        lfsr    = 32'h72e7;
        beat    = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            beat    = 0;
            q_addr.delete();
            q_len.delete();
            q_id.delete();
        end else begin
            // Next beat only once the current one is taken
            if (!rvalid || rready) begin
                lfsr = lfsr_step(lfsr);
                if (q_addr.size() > 0 && lfsr[0]) begin
                    rvalid <= 1'b1;
                    rid    <= q_id[0];
                    rdata  <= {32'h0, q_addr[0] + 32'(beat * 8)};
                    rlast  <= (beat == int'(q_len[0]));
                    if (beat == int'(q_len[0])) begin
                        beat = 0;
                        void'(q_addr.pop_front());
                        void'(q_len.pop_front());
                        void'(q_id.pop_front());
                    end else begin
                        beat = beat + 1;
                    end
                end else begin
                    rvalid <= 1'b0;
                end
            end
            if (arvalid && arready) begin
                q_addr.push_back(araddr);
                q_len.push_back(arlen);
                q_id.push_back(arid);
            end
            lfsr = lfsr_step(lfsr);
            arready <= lfsr[0];
        end
    end

endmodule

// ==== bench/dma_props.sv ====
// ==============================
// AR and channel protocol checks
// ==============================

`timescale 1ns/1ps

module dma_props #(
    parameter int addr_width = 32,
    parameter int id_width   = 4,
    parameter int max_burst  = 8
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        arvalid,
    input logic                        arready,
    input logic [id_width-1:0]         arid,
    input logic [addr_width-1:0]       araddr,
    input logic [dma_pkg::ARLEN_W-1:0] arlen,
    input logic                        rready,
    input logic [id_width-1:0]         rid,
    input logic                        ch0_busy,
    input logic                        ch0_done,
    input logic                        ch1_busy,
    input logic                        ch1_done,
    input logic                        ch0_fifo_full,
    input logic                        ch1_fifo_full
);

    // Payload holds while the request waits
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(arid) && $stable(araddr) && $stable(arlen))
        else $error("AR payload changed before arready");

    arlen_max: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> arlen < dma_pkg::ARLEN_W'(max_burst))
        else $error("arlen exceeds the burst limit");

    done0_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ch0_done |=> !ch0_busy)
        else $error("channel 0 still busy after done");

    done1_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ch1_done |=> !ch1_busy)
        else $error("channel 1 still busy after done");

    // No beat accepted into a full FIFO
    full0_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rready && (rid == id_width'(dma_pkg::CH0_ID)) |-> !ch0_fifo_full)
        else $error("rready raised for full channel 0 FIFO");

    full1_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rready && (rid == id_width'(dma_pkg::CH1_ID)) |-> !ch1_fifo_full)
        else $error("rready raised for full channel 1 FIFO");

endmodule

bind dma_top dma_props #(
    .addr_width(addr_width), .id_width(id_width), .max_burst(max_burst)
) u_props (
    .clk(clk), .rst_n(rst_n),
    .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr), .arlen(arlen),
    .rready(rready), .rid(rid),
    .ch0_busy(ch0_busy), .ch0_done(ch0_done), .ch1_busy(ch1_busy), .ch1_done(ch1_done),
    .ch0_fifo_full(ch0_fifo_full), .ch1_fifo_full(ch1_fifo_full)
);

// ==== bench/tb_dma_top.sv ====
// ==============================
// Testbench for the two-channel DMA
// ==============================

`timescale 1ns/1ps

module tb_dma_top;

    logic        clk;
    logic        rst_n;
    logic        ch0_start, ch0_abort, ch1_start, ch1_abort;
    logic [31:0] ch0_src_addr, ch1_src_addr, ch0_len, ch1_len;
    logic        ch0_rd_ready = 1'b0;
    logic        ch1_rd_ready = 1'b0;
    logic        ch0_busy, ch0_done, ch0_rd_valid, ch1_busy, ch1_done, ch1_rd_valid;
    logic [63:0] ch0_rd_data, ch1_rd_data;
    logic [31:0] ch0_total_bytes, ch1_total_bytes;
    logic [3:0]  arid, rid;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic        arvalid, arready, rlast, rvalid, rready;
    logic [63:0] rdata;

    logic [31:0] lfsr = 32'h72e7;
    logic        stall1 = 1'b0;
    logic        hold0 = 1'b0;
    logic        hold1 = 1'b0;
    logic        clr0, clr1, clr_mon;
    logic [31:0] base0, base1;
    int          got0, got1, data_errs0, data_errs1;
    int          done_cnt0, done_cnt1, ar_cnt;
    logic [3:0]  first_arid;
    logic        arvalid_seen;
    int          errors, tests_run, tests_failed, errs_before, n;
    string       test_name;

    dma_top dut0 (.*);
    axi_rd_mem u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Consumers, held or randomly stalled rd_ready
    always @(posedge clk) begin : consume
        logic [31:0] nxt;
        nxt = lfsr_step(lfsr);
        ch0_rd_ready <= !hold0;
        if (hold1) begin
            ch1_rd_ready <= 1'b0;
        end else if (stall1) begin
            lfsr <= nxt;
            ch1_rd_ready <= nxt[0];
        end else begin
            ch1_rd_ready <= 1'b1;
        end
        if (clr0) begin
            got0 <= 0;
        end else if (ch0_rd_valid && ch0_rd_ready) begin
            assert (ch0_rd_data == {32'h0, base0 + 32'(got0 * 8)}) else begin
                $display("ERROR %s ch0 beat %0d: expected %h actual %h", test_name, got0,
                         {32'h0, base0 + 32'(got0 * 8)}, ch0_rd_data);
                data_errs0 <= data_errs0 + 1;
            end
            got0 <= got0 + 1;
        end
        if (clr1) begin
            got1 <= 0;
        end else if (ch1_rd_valid && ch1_rd_ready) begin
            assert (ch1_rd_data == {32'h0, base1 + 32'(got1 * 8)}) else begin
                $display("ERROR %s ch1 beat %0d: expected %h actual %h", test_name, got1,
                         {32'h0, base1 + 32'(got1 * 8)}, ch1_rd_data);
                data_errs1 <= data_errs1 + 1;
            end
            got1 <= got1 + 1;
        end
    end

    // Done pulses and AR handshakes since the last start
    always @(posedge clk) begin
        if (clr_mon) begin
            done_cnt0    <= 0;
            done_cnt1    <= 0;
            ar_cnt       <= 0;
            arvalid_seen <= 1'b0;
        end else begin
            if (ch0_done)
                done_cnt0 <= done_cnt0 + 1;
            if (ch1_done)
                done_cnt1 <= done_cnt1 + 1;
            if (arvalid)
                arvalid_seen <= 1'b1;
            if (arvalid && arready) begin
                if (ar_cnt == 0)
                    first_arid <= arid;
                ar_cnt <= ar_cnt + 1;
            end
        end
    end

    function automatic int err_total();
        err_total = errors + data_errs0 + data_errs1;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    function automatic bit cond_met(input int which, input int target);
        case (which)
            0: cond_met = (done_cnt0 != 0);
            1: cond_met = (done_cnt1 != 0);
            2: cond_met = (got0 >= target);
            3: cond_met = (got1 >= target);
            4: cond_met = !ch0_busy;
            5: cond_met = !ch0_rd_valid;
            6: cond_met = rvalid && rready && (rid == 4'(dma_pkg::CH0_ID)) && !rlast;
            // Beat waiting on a full FIFO
            7: cond_met = rvalid && !rready && (rid == 4'(dma_pkg::CH0_ID));
            8: cond_met = rvalid && !rready && (rid == 4'(dma_pkg::CH1_ID));
            default: cond_met = 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int which, input int target, input string what);
        for (int i = 0; i < 3000; i++) begin
            @(posedge clk);
            if (cond_met(which, target))
                return;
        end
        $display("%s: timeout waiting for %s", test_name, what);
        errors++;
    endtask

    task automatic start_chans(input bit s0, input logic [31:0] a0, input logic [31:0] l0,
                               input bit s1, input logic [31:0] a1, input logic [31:0] l1);
        @(posedge clk);
        ch0_start    <= s0;
        ch0_src_addr <= a0;
        ch0_len      <= l0;
        base0        <= a0;
        clr0         <= s0;
        ch1_start    <= s1;
        ch1_src_addr <= a1;
        ch1_len      <= l1;
        base1        <= a1;
        clr1         <= s1;
        clr_mon      <= 1'b1;
        @(posedge clk);
        ch0_start <= 1'b0;
        ch1_start <= 1'b0;
        clr0      <= 1'b0;
        clr1      <= 1'b0;
        clr_mon   <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        errs_before = err_total();
    endtask

    task automatic end_test();
        tests_run++;
        if (err_total() != errs_before)
            tests_failed++;
        $display("test %s: %s", test_name, (err_total() == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        rst_n = 1'b0;
        ch0_start = 1'b0;
        ch0_abort = 1'b0;
        ch1_start = 1'b0;
        ch1_abort = 1'b0;
        ch0_src_addr = '0;
        ch1_src_addr = '0;
        ch0_len = '0;
        ch1_len = '0;
        clr0 = 1'b1;
        clr1 = 1'b1;
        clr_mon = 1'b1;
        base0 = '0;
        base1 = '0;
        data_errs0 = 0;
        data_errs1 = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        clr0 <= 1'b0;
        clr1 <= 1'b0;
        clr_mon <= 1'b0;

        begin_test("single_ch0");
        start_chans(1, 32'h1000, 32'd24, 0, 32'h0, 32'h0);
        wait_until(0, 0, "ch0 done");
        wait_until(2, 3, "ch0 beats");
        repeat (3) @(posedge clk);
        check("done pulses", 32'd1, 32'(done_cnt0));
        check("beats", 32'd3, 32'(got0));
        check("total_bytes", 32'd24, ch0_total_bytes);
        end_test();

        // FIFO fills first, then random stalls
        begin_test("multi_burst_ch1");
        stall1 <= 1'b1;
        hold1  <= 1'b1;
        start_chans(0, 32'h0, 32'h0, 1, 32'h8000, 32'd160);
        wait_until(8, 0, "ch1 FIFO back-pressure");
        hold1 <= 1'b0;
        wait_until(1, 0, "ch1 done");
        wait_until(3, 20, "ch1 beats");
        stall1 <= 1'b0;
        check("beats", 32'd20, 32'(got1));
        check("total_bytes", 32'd160, ch1_total_bytes);
        end_test();

        begin_test("both_channels");
        start_chans(1, 32'h2000, 32'd80, 1, 32'h3000, 32'd96);
        wait_until(0, 0, "ch0 done");
        wait_until(1, 0, "ch1 done");
        wait_until(2, 10, "ch0 beats");
        wait_until(3, 12, "ch1 beats");
        check("first arid", 32'(dma_pkg::CH0_ID), 32'(first_arid));
        check("ch0 beats", 32'd10, 32'(got0));
        check("ch1 beats", 32'd12, 32'(got1));
        end_test();

        begin_test("abort_ch0");
        hold0 <= 1'b1;
        start_chans(1, 32'h4000, 32'd512, 0, 32'h0, 32'h0);
        wait_until(7, 0, "ch0 FIFO back-pressure");
        hold0 <= 1'b0;
        wait_until(6, 0, "ch0 mid-burst beat");
        ch0_abort <= 1'b1;
        @(posedge clk);
        ch0_abort <= 1'b0;
        wait_until(4, 0, "ch0 idle");
        wait_until(5, 0, "ch0 FIFO drain");
        check("done pulses", 32'd0, 32'(done_cnt0));
        check("whole bursts", 32'd0, ch0_total_bytes % 32'd64);
        check("short total", 32'd1, 32'(ch0_total_bytes < 32'd512));
        start_chans(1, 32'h5000, 32'd16, 0, 32'h0, 32'h0);
        wait_until(0, 0, "ch0 done after restart");
        wait_until(2, 2, "ch0 beats after restart");
        check("restart total_bytes", 32'd16, ch0_total_bytes);
        end_test();

        // Done lands a fixed two cycles after start
        begin_test("zero_length");
        @(posedge clk);
        ch1_start <= 1'b1;
        ch1_len   <= '0;
        clr_mon   <= 1'b1;
        for (n = 1; n < 20; n++) begin
            @(posedge clk);
            if (n == 1) begin
                ch1_start <= 1'b0;
                clr_mon   <= 1'b0;
            end
            if (ch1_done)
                break;
        end
        check("done edge", 32'd3, 32'(n));
        check("arvalid seen", 32'd0, 32'(arvalid_seen));
        end_test();

        repeat (2) @(posedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total());
        if (tests_failed == 0 && err_total() == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/dma_pkg.sv
logic/chan_desc_regs.sv
logic/burst_engine.sv
logic/beat_fifo.sv
logic/ar_arbiter.sv
logic/dma_top.sv
bench/axi_rd_mem.sv
bench/dma_props.sv
bench/tb_dma_top.sv

// ==== logic/ar_arbiter.sv ====
// ==============================
// AR arbiter with grant hold, and
// R beat routing by rid
// ==============================

`timescale 1ns/1ps

module ar_arbiter #(
    parameter int addr_width = 32,
    parameter int id_width   = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req0,
    input  logic                        req1,
    input  logic [addr_width-1:0]       addr0,
    input  logic [addr_width-1:0]       addr1,
    input  logic [dma_pkg::ARLEN_W-1:0] len0,
    input  logic [dma_pkg::ARLEN_W-1:0] len1,
    input  logic                        arready,
    input  logic [id_width-1:0]         rid,
    input  logic                        rvalid,
    input  logic                        r_ready0,
    input  logic                        r_ready1,
    output logic                        ack0,
    output logic                        ack1,
    output logic [id_width-1:0]         arid,
    output logic [addr_width-1:0]       araddr,
    output logic [dma_pkg::ARLEN_W-1:0] arlen,
    output logic                        arvalid,
    output logic                        r_valid0,
    output logic                        r_valid1,
    output logic                        rready
);

    logic hold_q;
    logic sel1_q;
    logic sel1;
    logic rid_is0;
    logic rid_is1;

    // Channel 0 wins unless a stalled grant to channel 1 is pending
    assign sel1    = hold_q ? sel1_q : !req0;
    assign arvalid = sel1 ? req1 : req0;
    assign arid    = sel1 ? id_width'(dma_pkg::CH1_ID) : id_width'(dma_pkg::CH0_ID);
    assign araddr  = sel1 ? addr1 : addr0;
    assign arlen   = sel1 ? len1 : len0;
    assign ack0    = arvalid && arready && !sel1;
    assign ack1    = arvalid && arready && sel1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
            sel1_q <= 1'b0;
        end else begin
            hold_q <= arvalid && !arready;
            sel1_q <= sel1;
        end
    end

    // R channel back to the owner of rid
    assign rid_is0  = (rid == id_width'(dma_pkg::CH0_ID));
    assign rid_is1  = (rid == id_width'(dma_pkg::CH1_ID));
    assign r_valid0 = rvalid && rid_is0;
    assign r_valid1 = rvalid && rid_is1;
    assign rready   = (rid_is0 && r_ready0) || (rid_is1 && r_ready1);

endmodule

// ==== logic/beat_fifo.sv ====
// ==============================
// Read beat FIFO, flushed on start
// ==============================

`timescale 1ns/1ps

module beat_fifo #(
    parameter int data_width = 64,
    parameter int fifo_depth = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  push,
    input  logic [data_width-1:0] push_data,
    input  logic                  pop,
    output logic                  full,
    output logic [data_width-1:0] pop_data,
    output logic                  pop_valid
);

    localparam int ptr_w = $clog2(fifo_depth);

    logic [data_width-1:0] mem [fifo_depth];

    // One extra bit tells full from empty
    logic [ptr_w:0] wr_ptr;
    logic [ptr_w:0] rd_ptr;

    assign full      = (wr_ptr[ptr_w] != rd_ptr[ptr_w])
                    && (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
    assign pop_valid = (wr_ptr != rd_ptr);
    assign pop_data  = mem[rd_ptr[ptr_w-1:0]];

    always_ff @(posedge clk) begin
        if (push && !full)
            mem[wr_ptr[ptr_w-1:0]] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && pop_valid)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== logic/burst_engine.sv ====
// ==============================
// Burst FSM of one read channel
// ==============================

`timescale 1ns/1ps

module burst_engine #(
    parameter int data_width = 64,
    parameter int max_burst  = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        abort,
    input  logic [dma_pkg::LEN_W-1:0]   remaining,
    input  logic                        ar_ack,
    input  logic                        r_valid,
    input  logic                        r_last,
    input  logic                        fifo_full,
    output logic                        load,
    output logic                        advance,
    output logic                        flush,
    output logic                        ar_req,
    output logic [dma_pkg::ARLEN_W-1:0] burst_len,
    output logic                        r_ready,
    output logic                        push,
    output logic                        busy,
    output logic                        done
);

    localparam int bytes_per_beat = data_width / 8;
    localparam int beat_shift     = $clog2(bytes_per_beat);

    dma_pkg::chan_state_e state_q;
    dma_pkg::chan_state_e state_d;

    logic [dma_pkg::LEN_W-1:0] beats_left;
    logic                      abort_pend;

    // Burst length follows the remaining count directly
    assign beats_left = remaining >> beat_shift;
    assign burst_len  = (beats_left >= dma_pkg::LEN_W'(max_burst))
                      ? dma_pkg::ARLEN_W'(max_burst - 1)
                      : beats_left[dma_pkg::ARLEN_W-1:0] - 1'b1;

    assign load    = (state_q == dma_pkg::ST_IDLE) && start && !abort;
    assign flush   = load;
    assign ar_req  = (state_q == dma_pkg::ST_ADDR) && (beats_left != '0);
    assign r_ready = (state_q == dma_pkg::ST_DATA) && !fifo_full;
    assign push    = r_valid && r_ready;
    assign advance = push && r_last;
    assign busy    = (state_q != dma_pkg::ST_IDLE);
    assign done    = (state_q == dma_pkg::ST_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::ST_IDLE: begin
                if (load)
                    state_d = dma_pkg::ST_ADDR;
            end
            dma_pkg::ST_ADDR: begin
                // An accepted request opens the burst even under abort
                if (ar_ack)
                    state_d = dma_pkg::ST_DATA;
                else if (abort)
                    state_d = dma_pkg::ST_IDLE;
                else if (beats_left == '0)
                    state_d = dma_pkg::ST_DONE;
            end
            dma_pkg::ST_DATA: begin
                if (advance)
                    state_d = (abort_pend || abort) ? dma_pkg::ST_IDLE : dma_pkg::ST_ADDR;
            end
            default: state_d = dma_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= dma_pkg::ST_IDLE;
            abort_pend <= 1'b0;
        end else begin
            state_q <= state_d;
            // Abort inside an open burst waits for its rlast
            if (advance || load)
                abort_pend <= 1'b0;
            else if (abort && ((state_q == dma_pkg::ST_DATA) || ar_ack))
                abort_pend <= 1'b1;
        end
    end

endmodule

// ==== logic/chan_desc_regs.sv ====
// ==============================
// Per-channel descriptor registers:
// address, remaining bytes, byte count
// ==============================

`timescale 1ns/1ps

module chan_desc_regs #(
    parameter int data_width = 64,
    parameter int addr_width = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  logic                        advance,
    input  logic [addr_width-1:0]       src_addr,
    input  logic [dma_pkg::LEN_W-1:0]   len,
    input  logic [dma_pkg::ARLEN_W-1:0] burst_len,
    output logic [addr_width-1:0]       cur_addr,
    output logic [dma_pkg::LEN_W-1:0]   remaining,
    output logic [dma_pkg::LEN_W-1:0]   total_bytes
);

    localparam int bytes_per_beat = data_width / 8;
    localparam int beat_shift     = $clog2(bytes_per_beat);

    // Sub-beat bits of the length are dropped
    localparam logic [dma_pkg::LEN_W-1:0] low_mask = dma_pkg::LEN_W'(bytes_per_beat - 1);

    logic [dma_pkg::LEN_W-1:0] burst_bytes;

    assign burst_bytes = (dma_pkg::LEN_W'(burst_len) + 1'b1) << beat_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_addr    <= '0;
            remaining   <= '0;
            total_bytes <= '0;
        end else if (load) begin
            cur_addr    <= src_addr;
            remaining   <= len & ~low_mask;
            total_bytes <= '0;
        end else if (advance) begin
            // Whole burst accounted on its last beat
            cur_addr    <= cur_addr + addr_width'(burst_bytes);
            remaining   <= remaining - burst_bytes;
            total_bytes <= total_bytes + burst_bytes;
        end
    end

endmodule

// ==== logic/dma_pkg.sv ====
// ==============================
// Shared types and constants of the
// two-channel read DMA engine
// ==============================

package dma_pkg;

    // Burst FSM states of one channel
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_DONE
    } chan_state_e;

    // AXI IDs, also used to route R beats back
    localparam int unsigned CH0_ID = 0;
    localparam int unsigned CH1_ID = 1;

    // Transfer length and byte counters
    localparam int LEN_W = 32;

    // AXI4 arlen field
    localparam int ARLEN_W = 8;

endpackage

// ==== logic/dma_top.sv ====
// ==============================
// Two-channel read DMA top level
// ==============================

`timescale 1ns/1ps

module dma_top #(
    parameter int data_width = 64,
    parameter int addr_width = 32,
    parameter int id_width   = 4,
    parameter int fifo_depth = 16,
    parameter int max_burst  = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Channel 0, weights
    input  logic                        ch0_start,
    input  logic                        ch0_abort,
    input  logic [addr_width-1:0]       ch0_src_addr,
    input  logic [dma_pkg::LEN_W-1:0]   ch0_len,
    input  logic                        ch0_rd_ready,
    output logic                        ch0_busy,
    output logic                        ch0_done,
    output logic [data_width-1:0]       ch0_rd_data,
    output logic                        ch0_rd_valid,
    output logic [dma_pkg::LEN_W-1:0]   ch0_total_bytes,
    // Channel 1, inputs
    input  logic                        ch1_start,
    input  logic                        ch1_abort,
    input  logic [addr_width-1:0]       ch1_src_addr,
    input  logic [dma_pkg::LEN_W-1:0]   ch1_len,
    input  logic                        ch1_rd_ready,
    output logic                        ch1_busy,
    output logic                        ch1_done,
    output logic [data_width-1:0]       ch1_rd_data,
    output logic                        ch1_rd_valid,
    output logic [dma_pkg::LEN_W-1:0]   ch1_total_bytes,
    // AXI4 read master
    output logic [id_width-1:0]         arid,
    output logic [addr_width-1:0]       araddr,
    output logic [dma_pkg::ARLEN_W-1:0] arlen,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic [id_width-1:0]         rid,
    input  logic [data_width-1:0]       rdata,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready
);

    logic                        ch0_load;
    logic                        ch0_advance;
    logic                        ch0_flush;
    logic                        ch0_ar_req;
    logic                        ch0_ar_ack;
    logic                        ch0_r_valid;
    logic                        ch0_r_ready;
    logic                        ch0_push;
    logic                        ch0_fifo_full;
    logic [dma_pkg::ARLEN_W-1:0] ch0_burst_len;
    logic [addr_width-1:0]       ch0_cur_addr;
    logic [dma_pkg::LEN_W-1:0]   ch0_remaining;

    logic                        ch1_load;
    logic                        ch1_advance;
    logic                        ch1_flush;
    logic                        ch1_ar_req;
    logic                        ch1_ar_ack;
    logic                        ch1_r_valid;
    logic                        ch1_r_ready;
    logic                        ch1_push;
    logic                        ch1_fifo_full;
    logic [dma_pkg::ARLEN_W-1:0] ch1_burst_len;
    logic [addr_width-1:0]       ch1_cur_addr;
    logic [dma_pkg::LEN_W-1:0]   ch1_remaining;

    // Channel 0
    chan_desc_regs #(.data_width(data_width), .addr_width(addr_width)) u_regs0 (
        .clk(clk), .rst_n(rst_n),
        .load(ch0_load), .advance(ch0_advance),
        .src_addr(ch0_src_addr), .len(ch0_len), .burst_len(ch0_burst_len),
        .cur_addr(ch0_cur_addr), .remaining(ch0_remaining),
        .total_bytes(ch0_total_bytes)
    );

    burst_engine #(.data_width(data_width), .max_burst(max_burst)) u_eng0 (
        .clk(clk), .rst_n(rst_n),
        .start(ch0_start), .abort(ch0_abort), .remaining(ch0_remaining),
        .ar_ack(ch0_ar_ack), .r_valid(ch0_r_valid), .r_last(rlast),
        .fifo_full(ch0_fifo_full),
        .load(ch0_load), .advance(ch0_advance), .flush(ch0_flush),
        .ar_req(ch0_ar_req), .burst_len(ch0_burst_len),
        .r_ready(ch0_r_ready), .push(ch0_push),
        .busy(ch0_busy), .done(ch0_done)
    );

    beat_fifo #(.data_width(data_width), .fifo_depth(fifo_depth)) u_fifo0 (
        .clk(clk), .rst_n(rst_n), .flush(ch0_flush),
        .push(ch0_push), .push_data(rdata), .pop(ch0_rd_ready),
        .full(ch0_fifo_full), .pop_data(ch0_rd_data), .pop_valid(ch0_rd_valid)
    );

    // Channel 1
    chan_desc_regs #(.data_width(data_width), .addr_width(addr_width)) u_regs1 (
        .clk(clk), .rst_n(rst_n),
        .load(ch1_load), .advance(ch1_advance),
        .src_addr(ch1_src_addr), .len(ch1_len), .burst_len(ch1_burst_len),
        .cur_addr(ch1_cur_addr), .remaining(ch1_remaining),
        .total_bytes(ch1_total_bytes)
    );

    burst_engine #(.data_width(data_width), .max_burst(max_burst)) u_eng1 (
        .clk(clk), .rst_n(rst_n),
        .start(ch1_start), .abort(ch1_abort), .remaining(ch1_remaining),
        .ar_ack(ch1_ar_ack), .r_valid(ch1_r_valid), .r_last(rlast),
        .fifo_full(ch1_fifo_full),
        .load(ch1_load), .advance(ch1_advance), .flush(ch1_flush),
        .ar_req(ch1_ar_req), .burst_len(ch1_burst_len),
        .r_ready(ch1_r_ready), .push(ch1_push),
        .busy(ch1_busy), .done(ch1_done)
    );

    beat_fifo #(.data_width(data_width), .fifo_depth(fifo_depth)) u_fifo1 (
        .clk(clk), .rst_n(rst_n), .flush(ch1_flush),
        .push(ch1_push), .push_data(rdata), .pop(ch1_rd_ready),
        .full(ch1_fifo_full), .pop_data(ch1_rd_data), .pop_valid(ch1_rd_valid)
    );

    // Shared AR channel and R routing
    ar_arbiter #(.addr_width(addr_width), .id_width(id_width)) u_arb (
        .clk(clk), .rst_n(rst_n),
        .req0(ch0_ar_req), .req1(ch1_ar_req),
        .addr0(ch0_cur_addr), .addr1(ch1_cur_addr),
        .len0(ch0_burst_len), .len1(ch1_burst_len),
        .arready(arready), .rid(rid), .rvalid(rvalid),
        .r_ready0(ch0_r_ready), .r_ready1(ch1_r_ready),
        .ack0(ch0_ar_ack), .ack1(ch1_ar_ack),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
        .r_valid0(ch0_r_valid), .r_valid1(ch1_r_valid), .rready(rready)
    );

endmodule
